//--- logic/rob_consts.svh
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// queue sizing
`define ROB_DEPTH        16
`define ROB_STALL_LEVEL  12   // ready drops at this occupancy

// major opcodes handled by the rob
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111

// funct3 of the alu group
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct7 marking sub and sra
`define F7_ALT      7'b0100000

`endif

//--- logic/rob_pkg.sv
package rob_pkg;

  // entry index into the queue
  typedef logic [3:0]  rob_tag_t;

  // occupancy needs one bit more than a tag to hold 16
  typedef logic [4:0]  rob_cnt_t;

  typedef logic [4:0]  reg_idx_t;   // x0..x31
  typedef logic [31:0] xlen_t;
  typedef logic [31:0] instr_t;

  // life of one entry
  typedef enum logic [1:0] {
    ST_NEW    = 2'd0,   // enqueued but not decoded yet
    ST_ISSUED = 2'd1,   // waiting on a cdb result
    ST_DONE   = 2'd2
  } entry_state_t;

  // reservation station operations
  typedef enum logic [4:0] {
    ADD  = 5'd0,
    SUB  = 5'd1,
    AND  = 5'd2,
    OR   = 5'd3,
    XOR  = 5'd4,
    SLL  = 5'd5,
    SRL  = 5'd6,
    SRA  = 5'd7,
    SLT  = 5'd8,
    SLTU = 5'd9
  } alu_op_t;

endpackage

//--- logic/rob_store.sv
`timescale 1ns/100ps
`include "rob_consts.svh"

module rob_store (
  input  logic              clk,
  input  logic              rst,
  input  rob_pkg::instr_t   instr_i,
  input  rob_pkg::xlen_t    pc_i,
  input  logic              cdb0_valid_i,
  input  rob_pkg::rob_tag_t cdb0_tag_i,
  input  rob_pkg::xlen_t    cdb0_value_i,
  input  logic              cdb1_valid_i,
  input  rob_pkg::rob_tag_t cdb1_tag_i,
  input  rob_pkg::xlen_t    cdb1_value_i,
  input  logic              issue_valid_i,
  input  rob_pkg::rob_tag_t issue_tag_i,
  input  logic              complete_valid_i,
  input  rob_pkg::rob_tag_t complete_tag_i,
  input  rob_pkg::xlen_t    complete_value_i,
  input  rob_pkg::rob_tag_t lookup1_tag_i,
  input  rob_pkg::rob_tag_t lookup2_tag_i,
  output logic              lookup1_done_o,
  output rob_pkg::xlen_t    lookup1_value_o,
  output logic              lookup2_done_o,
  output rob_pkg::xlen_t    lookup2_value_o,
  output logic              newest_new_o,
  output rob_pkg::rob_tag_t newest_tag_o,
  output rob_pkg::instr_t   newest_instr_o,
  output rob_pkg::xlen_t    newest_pc_o,
  output logic              instr_ready_o,
  output logic              retire_valid_o,
  output rob_pkg::reg_idx_t retire_rd_o,
  output rob_pkg::xlen_t    retire_value_o,
  output rob_pkg::rob_tag_t retire_tag_o,
  output rob_pkg::rob_tag_t head_tag_o
);
  import rob_pkg::*;

  entry_state_t state_q [`ROB_DEPTH];
  instr_t       instr_q [`ROB_DEPTH];
  xlen_t        pc_q    [`ROB_DEPTH];
  xlen_t        value_q [`ROB_DEPTH];

  rob_tag_t head_q, tail_q;
  rob_cnt_t count_q, count_next;
  rob_tag_t newest;
  logic     enq, ret;
  logic [6:0] head_op;
  logic     head_writes_rd;

  // result seen either in the entry or on a bus this cycle
  function automatic logic tag_done(rob_tag_t tag);
    return (state_q[tag] == ST_DONE) ||
           (cdb0_valid_i && cdb0_tag_i == tag) ||
           (cdb1_valid_i && cdb1_tag_i == tag);
  endfunction

  function automatic xlen_t tag_value(rob_tag_t tag);
    if (cdb0_valid_i && cdb0_tag_i == tag) return cdb0_value_i;
    if (cdb1_valid_i && cdb1_tag_i == tag) return cdb1_value_i;
    return value_q[tag];
  endfunction

  assign enq = instr_i[1:0] != 2'b00;   // low bits set means a word is present
  assign ret = (count_q != '0) && (state_q[head_q] == ST_DONE);
  assign count_next = count_q + rob_cnt_t'(enq) - rob_cnt_t'(ret);

  always_comb begin
    lookup1_done_o  = tag_done(lookup1_tag_i);
    lookup1_value_o = tag_value(lookup1_tag_i);
    lookup2_done_o  = tag_done(lookup2_tag_i);
    lookup2_value_o = tag_value(lookup2_tag_i);
  end

  // newest entry sits just behind the tail
  assign newest         = tail_q - 1'b1;
  assign newest_new_o   = (count_q != '0) && (state_q[newest] == ST_NEW);
  assign newest_tag_o   = newest;
  assign newest_instr_o = instr_q[newest];
  assign newest_pc_o    = pc_q[newest];

  // only the alu and upper-immediate groups own a result
  always_comb begin
    head_op = instr_q[head_q][6:0];
    head_writes_rd = (head_op == `OPC_OP) || (head_op == `OPC_OP_IMM) ||
                     (head_op == `OPC_LUI) || (head_op == `OPC_AUIPC);
  end

  assign retire_valid_o = ret;
  assign retire_rd_o    = head_writes_rd ? instr_q[head_q][11:7] : '0;
  assign retire_value_o = head_writes_rd ? value_q[head_q] : '0;
  assign retire_tag_o   = head_q;
  assign head_tag_o     = head_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      head_q        <= '0;
      tail_q        <= '0;
      count_q       <= '0;
      instr_ready_o <= 1'b0;
      for (int i = 0; i < `ROB_DEPTH; i++) begin
        state_q[i] <= ST_NEW;
      end
    end else begin
      if (enq) begin
        state_q[tail_q] <= ST_NEW;
        tail_q          <= tail_q + 1'b1;
      end
      if (issue_valid_i)    state_q[issue_tag_i]    <= ST_ISSUED;
      if (complete_valid_i) state_q[complete_tag_i] <= ST_DONE;
      if (cdb0_valid_i)     state_q[cdb0_tag_i]     <= ST_DONE;
      if (cdb1_valid_i)     state_q[cdb1_tag_i]     <= ST_DONE;
      if (ret) head_q <= head_q + 1'b1;
      count_q       <= count_next;
      instr_ready_o <= count_next < rob_cnt_t'(`ROB_STALL_LEVEL);
    end
  end

  // entry payload
  always_ff @(posedge clk) begin
    if (enq) begin
      instr_q[tail_q] <= instr_i;
      pc_q[tail_q]    <= pc_i;
    end
    if (complete_valid_i) value_q[complete_tag_i] <= complete_value_i;
    if (cdb0_valid_i)     value_q[cdb0_tag_i]     <= cdb0_value_i;
    if (cdb1_valid_i)     value_q[cdb1_tag_i]     <= cdb1_value_i;
  end

endmodule

//--- logic/reg_rename.sv
`timescale 1ns/100ps

module reg_rename (
  input  logic              clk,
  input  logic              rst,
  input  rob_pkg::reg_idx_t rs1_i,
  input  rob_pkg::reg_idx_t rs2_i,
  input  logic              rename_valid_i,
  input  rob_pkg::reg_idx_t rename_rd_i,
  input  rob_pkg::rob_tag_t rename_tag_i,
  input  logic              retire_valid_i,
  input  rob_pkg::reg_idx_t retire_rd_i,
  input  rob_pkg::xlen_t    retire_value_i,
  input  rob_pkg::rob_tag_t retire_tag_i,
  output logic              rs1_busy_o,
  output rob_pkg::rob_tag_t rs1_tag_o,
  output rob_pkg::xlen_t    rs1_value_o,
  output logic              rs2_busy_o,
  output rob_pkg::rob_tag_t rs2_tag_o,
  output rob_pkg::xlen_t    rs2_value_o
);
  import rob_pkg::*;

  xlen_t       regs_q [32];
  rob_tag_t    tag_q  [32];
  logic [31:0] busy_q;        // producer still in flight

  logic retire_hit, rename_hit;

  assign retire_hit = retire_valid_i && (retire_rd_i != '0);
  assign rename_hit = rename_valid_i && (rename_rd_i != '0);

  // x0 is never written or marked busy, so it reads as zero
  assign rs1_busy_o  = busy_q[rs1_i];
  assign rs1_tag_o   = tag_q[rs1_i];
  assign rs1_value_o = regs_q[rs1_i];
  assign rs2_busy_o  = busy_q[rs2_i];
  assign rs2_tag_o   = tag_q[rs2_i];
  assign rs2_value_o = regs_q[rs2_i];

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
        tag_q[i]  <= '0;
      end
    end else begin
      if (retire_hit) begin
        regs_q[retire_rd_i] <= retire_value_i;
        // a younger writer keeps ownership
        if (busy_q[retire_rd_i] && tag_q[retire_rd_i] == retire_tag_i) begin
          busy_q[retire_rd_i] <= 1'b0;
        end
      end
      // rename comes later and wins over a clear
      if (rename_hit) begin
        busy_q[rename_rd_i] <= 1'b1;
        tag_q[rename_rd_i]  <= rename_tag_i;
      end
    end
  end

endmodule

//--- logic/rs_dispatch.sv
`timescale 1ns/100ps
`include "rob_consts.svh"

module rs_dispatch (
  input  logic              clk,
  input  logic              rst,
  input  logic              newest_new_i,
  input  rob_pkg::rob_tag_t newest_tag_i,
  input  rob_pkg::instr_t   newest_instr_i,
  input  rob_pkg::xlen_t    newest_pc_i,
  input  logic              rs1_busy_i,
  input  rob_pkg::rob_tag_t rs1_tag_i,
  input  rob_pkg::xlen_t    rs1_value_i,
  input  logic              rs2_busy_i,
  input  rob_pkg::rob_tag_t rs2_tag_i,
  input  rob_pkg::xlen_t    rs2_value_i,
  input  logic              lookup1_done_i,
  input  rob_pkg::xlen_t    lookup1_value_i,
  input  logic              lookup2_done_i,
  input  rob_pkg::xlen_t    lookup2_value_i,
  output rob_pkg::reg_idx_t rs1_o,
  output rob_pkg::reg_idx_t rs2_o,
  output rob_pkg::rob_tag_t lookup1_tag_o,
  output rob_pkg::rob_tag_t lookup2_tag_o,
  output logic              issue_valid_o,
  output rob_pkg::rob_tag_t issue_tag_o,
  output logic              complete_valid_o,
  output rob_pkg::rob_tag_t complete_tag_o,
  output rob_pkg::xlen_t    complete_value_o,
  output logic              rename_valid_o,
  output rob_pkg::reg_idx_t rename_rd_o,
  output rob_pkg::rob_tag_t rename_tag_o,
  output logic              rs_valid_o,
  output rob_pkg::alu_op_t  rs_op_o,
  output rob_pkg::xlen_t    rs_vj_o,
  output rob_pkg::xlen_t    rs_vk_o,
  output logic              rs_qj_valid_o,
  output rob_pkg::rob_tag_t rs_qj_o,
  output logic              rs_qk_valid_o,
  output rob_pkg::rob_tag_t rs_qk_o,
  output rob_pkg::rob_tag_t rs_dest_o
);
  import rob_pkg::*;

  logic [6:0] opcode, funct7;
  logic [2:0] funct3;
  reg_idx_t   rd;
  logic       is_op, is_op_imm, is_lui, is_auipc, is_shift;
  logic       alu_go, upper_go;
  xlen_t      imm_i, imm_u, shamt;
  alu_op_t    op_d;
  xlen_t      vj_d, vk_d;
  logic       qj_valid_d, qk_valid_d;

  // register value, forwarded rob value, or nothing while waiting
  function automatic xlen_t pick_value(logic busy, logic done, xlen_t reg_v, xlen_t rob_v);
    if (!busy) return reg_v;
    if (done) return rob_v;
    return '0;
  endfunction

  assign opcode = newest_instr_i[6:0];
  assign rd     = newest_instr_i[11:7];
  assign funct3 = newest_instr_i[14:12];
  assign funct7 = newest_instr_i[31:25];

  assign is_op     = opcode == `OPC_OP;
  assign is_op_imm = opcode == `OPC_OP_IMM;
  assign is_lui    = opcode == `OPC_LUI;
  assign is_auipc  = opcode == `OPC_AUIPC;
  assign is_shift  = (funct3 == `F3_SLL) || (funct3 == `F3_SRL_SRA);

  assign imm_i = {{20{newest_instr_i[31]}}, newest_instr_i[31:20]};
  assign imm_u = {newest_instr_i[31:12], 12'b0};
  assign shamt = {27'b0, newest_instr_i[24:20]};

  assign alu_go   = newest_new_i && (is_op || is_op_imm);
  assign upper_go = newest_new_i && (is_lui || is_auipc);

  // source lookups go to both side units
  assign rs1_o         = newest_instr_i[19:15];
  assign rs2_o         = newest_instr_i[24:20];
  assign lookup1_tag_o = rs1_tag_i;
  assign lookup2_tag_o = rs2_tag_i;

  always_comb begin
    case (funct3)
      `F3_ADD_SUB: op_d = (is_op && funct7 == `F7_ALT) ? SUB : ADD;  // addi has no sub
      `F3_SLL:     op_d = SLL;
      `F3_SLT:     op_d = SLT;
      `F3_SLTU:    op_d = SLTU;
      `F3_XOR:     op_d = XOR;
      `F3_SRL_SRA: op_d = (funct7 == `F7_ALT) ? SRA : SRL;
      `F3_OR:      op_d = OR;
      `F3_AND:     op_d = AND;
      default:     op_d = ADD;
    endcase
  end

  always_comb begin
    qj_valid_d = rs1_busy_i && !lookup1_done_i;
    vj_d       = pick_value(rs1_busy_i, lookup1_done_i, rs1_value_i, lookup1_value_i);
    if (is_op) begin
      qk_valid_d = rs2_busy_i && !lookup2_done_i;
      vk_d       = pick_value(rs2_busy_i, lookup2_done_i, rs2_value_i, lookup2_value_i);
    end else begin
      qk_valid_d = 1'b0;
      vk_d       = is_shift ? shamt : imm_i;
    end
  end

  // issue alu work, finish everything else right here
  assign issue_valid_o    = alu_go;
  assign issue_tag_o      = newest_tag_i;
  assign complete_valid_o = newest_new_i && !alu_go;
  assign complete_tag_o   = newest_tag_i;
  assign complete_value_o = is_lui   ? imm_u :
                            is_auipc ? newest_pc_i + imm_u : '0;  // unknown opcodes give 0

  assign rename_valid_o = (alu_go || upper_go) && (rd != '0);
  assign rename_rd_o    = rd;
  assign rename_tag_o   = newest_tag_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      rs_valid_o <= 1'b0;
    end else begin
      rs_valid_o <= alu_go;
    end
  end

  // packet payload
  always_ff @(posedge clk) begin
    rs_op_o       <= op_d;
    rs_vj_o       <= vj_d;
    rs_vk_o       <= vk_d;
    rs_qj_valid_o <= qj_valid_d;
    rs_qj_o       <= qj_valid_d ? rs1_tag_i : '0;
    rs_qk_valid_o <= qk_valid_d;
    rs_qk_o       <= qk_valid_d ? rs2_tag_i : '0;
    rs_dest_o     <= newest_tag_i;
  end

endmodule

//--- logic/rob_top.sv
`timescale 1ns/100ps

module rob_top (
  input  logic              clk,
  input  logic              rst,
  input  rob_pkg::instr_t   instr_i,
  input  rob_pkg::xlen_t    pc_i,
  input  logic              cdb0_valid_i,
  input  rob_pkg::rob_tag_t cdb0_tag_i,
  input  rob_pkg::xlen_t    cdb0_value_i,
  input  logic              cdb1_valid_i,
  input  rob_pkg::rob_tag_t cdb1_tag_i,
  input  rob_pkg::xlen_t    cdb1_value_i,
  output logic              instr_ready_o,
  output logic              rs_valid_o,
  output rob_pkg::alu_op_t  rs_op_o,
  output rob_pkg::xlen_t    rs_vj_o,
  output rob_pkg::xlen_t    rs_vk_o,
  output logic              rs_qj_valid_o,
  output rob_pkg::rob_tag_t rs_qj_o,
  output logic              rs_qk_valid_o,
  output rob_pkg::rob_tag_t rs_qk_o,
  output rob_pkg::rob_tag_t rs_dest_o,
  output logic              retire_valid_o,
  output rob_pkg::reg_idx_t retire_rd_o,
  output rob_pkg::xlen_t    retire_value_o,
  output rob_pkg::rob_tag_t retire_tag_o,
  output rob_pkg::rob_tag_t head_tag_o
);
  import rob_pkg::*;

  // store <-> dispatch
  logic     lookup1_done, lookup2_done;
  xlen_t    lookup1_value, lookup2_value;
  rob_tag_t lookup1_tag, lookup2_tag;
  logic     newest_new;
  rob_tag_t newest_tag;
  instr_t   newest_instr;
  xlen_t    newest_pc;
  logic     issue_valid, complete_valid;
  rob_tag_t issue_tag, complete_tag;
  xlen_t    complete_value;

  // rename <-> dispatch
  reg_idx_t rs1, rs2, rename_rd;
  logic     rs1_busy, rs2_busy, rename_valid;
  rob_tag_t rs1_tag, rs2_tag, rename_tag;
  xlen_t    rs1_value, rs2_value;

  rob_store u_store (
    .clk, .rst, .instr_i, .pc_i,
    .cdb0_valid_i, .cdb0_tag_i, .cdb0_value_i,
    .cdb1_valid_i, .cdb1_tag_i, .cdb1_value_i,
    .issue_valid_i(issue_valid), .issue_tag_i(issue_tag),
    .complete_valid_i(complete_valid), .complete_tag_i(complete_tag),
    .complete_value_i(complete_value),
    .lookup1_tag_i(lookup1_tag), .lookup2_tag_i(lookup2_tag),
    .lookup1_done_o(lookup1_done), .lookup1_value_o(lookup1_value),
    .lookup2_done_o(lookup2_done), .lookup2_value_o(lookup2_value),
    .newest_new_o(newest_new), .newest_tag_o(newest_tag),
    .newest_instr_o(newest_instr), .newest_pc_o(newest_pc),
    .instr_ready_o,
    .retire_valid_o, .retire_rd_o, .retire_value_o, .retire_tag_o,
    .head_tag_o
  );

  reg_rename u_rename (
    .clk, .rst,
    .rs1_i(rs1), .rs2_i(rs2),
    .rename_valid_i(rename_valid), .rename_rd_i(rename_rd), .rename_tag_i(rename_tag),
    .retire_valid_i(retire_valid_o), .retire_rd_i(retire_rd_o),
    .retire_value_i(retire_value_o), .retire_tag_i(retire_tag_o),
    .rs1_busy_o(rs1_busy), .rs1_tag_o(rs1_tag), .rs1_value_o(rs1_value),
    .rs2_busy_o(rs2_busy), .rs2_tag_o(rs2_tag), .rs2_value_o(rs2_value)
  );

  rs_dispatch u_dispatch (
    .clk, .rst,
    .newest_new_i(newest_new), .newest_tag_i(newest_tag),
    .newest_instr_i(newest_instr), .newest_pc_i(newest_pc),
    .rs1_busy_i(rs1_busy), .rs1_tag_i(rs1_tag), .rs1_value_i(rs1_value),
    .rs2_busy_i(rs2_busy), .rs2_tag_i(rs2_tag), .rs2_value_i(rs2_value),
    .lookup1_done_i(lookup1_done), .lookup1_value_i(lookup1_value),
    .lookup2_done_i(lookup2_done), .lookup2_value_i(lookup2_value),
    .rs1_o(rs1), .rs2_o(rs2),
    .lookup1_tag_o(lookup1_tag), .lookup2_tag_o(lookup2_tag),
    .issue_valid_o(issue_valid), .issue_tag_o(issue_tag),
    .complete_valid_o(complete_valid), .complete_tag_o(complete_tag),
    .complete_value_o(complete_value),
    .rename_valid_o(rename_valid), .rename_rd_o(rename_rd), .rename_tag_o(rename_tag),
    .rs_valid_o, .rs_op_o, .rs_vj_o, .rs_vk_o,
    .rs_qj_valid_o, .rs_qj_o, .rs_qk_valid_o, .rs_qk_o, .rs_dest_o
  );

endmodule

//--- verif/rob_tb_table.svh
`ifndef ROB_TB_TABLE_SVH
`define ROB_TB_TABLE_SVH

// instr, dispatched, op, vj, vk, qj, qk (-1 none), result delay, retire rd, retire value
task automatic load_table();
  add_row(i_op(5, 0, 0, 1), 1, ADD, 0, 5, -1, -1, 0, 1, 5);
  add_row(i_op(7, 0, 0, 2), 1, ADD, 0, 7, -1, -1, 3, 2, 7);
  add_row(r_op(0, 2, 1, 0, 3), 1, ADD, 5, 0, -1, 1, 0, 3, 12);      // x2 still in flight
  add_row(r_op('h20, 1, 3, 0, 4), 1, SUB, 0, 5, 2, -1, 1, 4, 7);
  add_row(r_op(0, 2, 1, 4, 5), 1, XOR, 5, 0, -1, 1, 0, 5, 2);
  add_row(u_op(`OPC_LUI, 'h12345, 6), 0, ADD, 0, 0, -1, -1, 0, 6, 'h12345000);
  add_row(u_op(`OPC_AUIPC, 1, 7), 0, ADD, 0, 0, -1, -1, 0, 7, 'h2018);
  add_row(r_op(0, 7, 6, 0, 8), 1, ADD, 'h12345000, 'h2018, -1, -1, 2, 8, 'h12347018);
  add_row(i_op(4, 1, 1, 9), 1, SLL, 5, 4, -1, -1, 0, 9, 'h50);
  add_row(i_op(-16, 0, 0, 11), 1, ADD, 0, 'hfffffff0, -1, -1, 0, 11, 'hfffffff0);
  add_row(i_op('h402, 11, 5, 12), 1, SRA, 'hfffffff0, 2, -1, -1, 0, 12, 'hfffffffc);
  add_row(i_op(28, 11, 5, 13), 1, SRL, 'hfffffff0, 28, -1, -1, 0, 13, 'hf);
  add_row(r_op(0, 1, 11, 2, 14), 1, SLT, 'hfffffff0, 5, -1, -1, 0, 14, 1);
  add_row(r_op(0, 1, 11, 3, 15), 1, SLTU, 'hfffffff0, 5, -1, -1, 0, 15, 0);
  add_row(i_op('ha0, 1, 6, 16), 1, OR, 5, 'ha0, -1, -1, 0, 16, 'ha5);
  add_row(i_op('h7f, 11, 7, 17), 1, AND, 'hfffffff0, 'h7f, -1, -1, 0, 17, 'h70);
  add_row(r_op('h20, 1, 11, 5, 18), 1, SRA, 'hfffffff0, 5, -1, -1, 0, 18, 'hffffffff);
  add_row(r_op(0, 1, 1, 0, 0), 1, ADD, 5, 5, -1, -1, 0, 0, 10);      // write to x0
  add_row(r_op(0, 1, 0, 0, 19), 1, ADD, 0, 5, -1, -1, 0, 19, 5);
  add_row(32'h0000_0f83, 0, ADD, 0, 0, -1, -1, 0, 0, 0);             // unknown opcode
  // two writers of x20 where the younger one holds the queue
  add_row(i_op(1, 0, 0, 20), 1, ADD, 0, 1, -1, -1, 4, 20, 1);
  add_row(i_op(2, 0, 0, 20), 1, ADD, 0, 2, -1, -1, 30, 20, 2);
  add_row(r_op(0, 0, 20, 0, 21), 1, ADD, 0, 0, 5, -1, 0, 21, 2);
  add_row(i_op(3, 0, 0, 22), 1, ADD, 0, 3, -1, -1, 0, 22, 3);
  add_row(i_op(24, 0, 0, 26), 1, ADD, 0, 24, -1, -1, 2, 26, 24);
  add_row(i_op(25, 0, 0, 27), 1, ADD, 0, 25, -1, -1, 0, 27, 25);
  add_row(i_op(26, 0, 0, 28), 1, ADD, 0, 26, -1, -1, 1, 28, 26);
  add_row(i_op(27, 0, 0, 29), 1, ADD, 0, 27, -1, -1, 0, 29, 27);
  add_row(r_op(0, 20, 20, 0, 23), 1, ADD, 0, 0, 5, 5, 0, 23, 4);     // older x20 already retired
  add_row(i_op(29, 0, 0, 30), 1, ADD, 0, 29, -1, -1, 0, 30, 29);
  add_row(i_op(30, 0, 0, 31), 1, ADD, 0, 30, -1, -1, 0, 31, 30);
  add_row(i_op(31, 0, 0, 26), 1, ADD, 0, 31, -1, -1, 0, 26, 31);
  add_row(i_op(32, 0, 0, 27), 1, ADD, 0, 32, -1, -1, 0, 27, 32);     // 12th entry drops ready
  add_row(r_op(0, 22, 23, 0, 24), 1, ADD, 4, 3, -1, -1, 0, 24, 7);
  add_row(i_op('hff, 24, 4, 25), 1, XOR, 7, 'hff, -1, -1, 0, 25, 'hf8);
endtask

`endif

//--- verif/rob_tb.sv
`timescale 1ns/100ps
`include "rob_consts.svh"

module rob_tb;
  import rob_pkg::*;

  typedef struct packed {
    instr_t   instr;
    xlen_t    pc;
    logic     disp;
    alu_op_t  op;
    xlen_t    vj;
    xlen_t    vk;
    int       qj;      // -1 when the operand comes as a value
    int       qk;
    int       delay;
    reg_idx_t rd;
    xlen_t    value;
  } row_t;

  logic     clk, rst;
  instr_t   instr_i;
  xlen_t    pc_i;
  logic     cdb0_valid_i, cdb1_valid_i;
  rob_tag_t cdb0_tag_i, cdb1_tag_i;
  xlen_t    cdb0_value_i, cdb1_value_i;
  logic     instr_ready_o, rs_valid_o, rs_qj_valid_o, rs_qk_valid_o, retire_valid_o;
  alu_op_t  rs_op_o;
  xlen_t    rs_vj_o, rs_vk_o, retire_value_o;
  rob_tag_t rs_qj_o, rs_qk_o, rs_dest_o, retire_tag_o, head_tag_o;
  reg_idx_t retire_rd_o;

  row_t     rows [$];
  int       disp_q [$];
  int       errors = 0;
  logic [31:0] rng = 32'hdac51786;

  // reservation station model indexed by destination tag
  logic     pend_valid [16];
  alu_op_t  pend_op [16];
  xlen_t    pend_vj [16];
  xlen_t    pend_vk [16];
  logic     pend_qjv [16];
  logic     pend_qkv [16];
  rob_tag_t pend_qj [16];
  rob_tag_t pend_qk [16];
  int       pend_cnt [16];
  logic     seen [16];      // result already broadcast
  xlen_t    seen_val [16];

  rob_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic instr_t r_op(int f7, int rs2, int rs1, int f3, int rd);
    return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), `OPC_OP};
  endfunction

  function automatic instr_t i_op(int imm, int rs1, int f3, int rd);
    return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), `OPC_OP_IMM};
  endfunction

  function automatic instr_t u_op(logic [6:0] opc, int imm, int rd);
    return {20'(imm), 5'(rd), opc};
  endfunction

  function automatic xlen_t alu_result(alu_op_t op, xlen_t a, xlen_t b);
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << b[4:0];
      SRL:     return a >> b[4:0];
      SRA:     return $signed(a) >>> b[4:0];
      SLT:     return {31'b0, $signed(a) < $signed(b)};
      SLTU:    return {31'b0, a < b};
      default: return '0;
    endcase
  endfunction

  task automatic add_row(instr_t instr, logic disp, alu_op_t op, xlen_t vj, xlen_t vk,
                         int qj, int qk, int delay, reg_idx_t rd, xlen_t value);
    xlen_t pc;
    pc = 32'h1000 + 4 * rows.size();
    rows.push_back({instr, pc, disp, op, vj, vk, qj, qk, delay, rd, value});
  endtask

  `include "rob_tb_table.svh"

  task automatic report_mismatch(string what, int row, logic [31:0] exp, logic [31:0] act);
    errors++;
    $display("CHECK FAILED %s row %0d expected %h actual %h", what, row, exp, act);
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_error(string msg);
    errors++;
    $display("ERROR %s", msg);
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_packet();
    int   r;
    row_t e;
    assert (disp_q.size() > 0) else report_error("packet arrived for no dispatched row");
    r = disp_q.pop_front();
    e = rows[r];
    assert (rs_op_o == e.op) else report_mismatch("rs_op_o", r, e.op, rs_op_o);
    assert (rs_vj_o == e.vj) else report_mismatch("rs_vj_o", r, e.vj, rs_vj_o);
    assert (rs_vk_o == e.vk) else report_mismatch("rs_vk_o", r, e.vk, rs_vk_o);
    assert (rs_dest_o == 4'(r)) else report_mismatch("rs_dest_o", r, 4'(r), rs_dest_o);
    assert (rs_qj_valid_o == (e.qj >= 0))
      else report_mismatch("rs_qj_valid_o", r, e.qj >= 0, rs_qj_valid_o);
    assert (rs_qk_valid_o == (e.qk >= 0))
      else report_mismatch("rs_qk_valid_o", r, e.qk >= 0, rs_qk_valid_o);
    if (e.qj >= 0) begin
      assert (rs_qj_o == 4'(e.qj)) else report_mismatch("rs_qj_o", r, e.qj, rs_qj_o);
    end
    if (e.qk >= 0) begin
      assert (rs_qk_o == 4'(e.qk)) else report_mismatch("rs_qk_o", r, e.qk, rs_qk_o);
    end
    pend_valid[4'(r)] = 1'b1;
    pend_op[4'(r)]    = e.op;
    pend_vj[4'(r)]    = e.vj;
    pend_vk[4'(r)]    = e.vk;
    pend_qjv[4'(r)]   = e.qj >= 0;
    pend_qkv[4'(r)]   = e.qk >= 0;
    pend_qj[4'(r)]    = 4'(e.qj);
    pend_qk[4'(r)]    = 4'(e.qk);
    pend_cnt[4'(r)]   = e.delay;
  endtask

  // up to two results per cycle on randomly picked ports
  task automatic drive_results();
    int    used;
    logic  port, sel;
    logic  fired [16];
    xlen_t res;
    used = 0;
    port = next_random() & 1;
    cdb0_valid_i = 1'b0;
    cdb1_valid_i = 1'b0;
    for (int t = 0; t < 16; t++) begin
      fired[t] = 1'b0;
      if (!pend_valid[t]) continue;
      if (pend_qjv[t] && seen[pend_qj[t]]) begin
        pend_vj[t]  = seen_val[pend_qj[t]];
        pend_qjv[t] = 1'b0;
      end
      if (pend_qkv[t] && seen[pend_qk[t]]) begin
        pend_vk[t]  = seen_val[pend_qk[t]];
        pend_qkv[t] = 1'b0;
      end
      if (pend_qjv[t] || pend_qkv[t]) continue;
      if (pend_cnt[t] > 0) begin
        pend_cnt[t]--;
        continue;
      end
      if (used == 2) continue;
      res = alu_result(pend_op[t], pend_vj[t], pend_vk[t]);
      sel = (used == 0) ? port : !port;
      if (sel) begin
        cdb1_valid_i = 1'b1;
        cdb1_tag_i   = 4'(t);
        cdb1_value_i = res;
      end else begin
        cdb0_valid_i = 1'b1;
        cdb0_tag_i   = 4'(t);
        cdb0_value_i = res;
      end
      seen_val[t]   = res;
      fired[t]      = 1'b1;
      pend_valid[t] = 1'b0;
      used++;
    end
    // waiters pick these up next cycle
    for (int t = 0; t < 16; t++) begin
      if (fired[t]) seen[t] = 1'b1;
    end
  endtask

  initial begin
    int   cycle, limit, next_row, retired, occupancy;
    logic saw_stall;
    rob_tag_t tail;
    row_t e;
    instr_i      = '0;
    pc_i         = '0;
    cdb0_valid_i = 1'b0;
    cdb0_tag_i   = '0;
    cdb0_value_i = '0;
    cdb1_valid_i = 1'b0;
    cdb1_tag_i   = '0;
    cdb1_value_i = '0;
    rst          = 1'b1;
    cycle     = 0;
    next_row  = 0;
    retired   = 0;
    occupancy = 0;
    saw_stall = 1'b0;
    tail      = '0;
    for (int t = 0; t < 16; t++) begin
      pend_valid[t] = 1'b0;
      seen[t]       = 1'b0;
    end
    load_table();
    limit = 40 * rows.size() + 50;
    repeat (10) @(posedge clk);
    #10 rst = 1'b0;

    while (retired < rows.size()) begin
      @(posedge clk);
      #10;
      cycle++;
      assert (cycle < limit) else report_error("timeout, retires stopped coming");
      assert (instr_ready_o == (occupancy < `ROB_STALL_LEVEL))
        else report_mismatch("instr_ready_o", next_row, occupancy < 12, instr_ready_o);
      if (!instr_ready_o) saw_stall = 1'b1;
      // head is the oldest entry not yet retired
      assert (head_tag_o == 4'(retired))
        else report_mismatch("head_tag_o", retired, 4'(retired), head_tag_o);
      if (rs_valid_o) check_packet();
      if (retire_valid_o) begin
        e = rows[retired];
        assert (retire_rd_o == e.rd)
          else report_mismatch("retire_rd_o", retired, e.rd, retire_rd_o);
        assert (retire_value_o == e.value)
          else report_mismatch("retire_value_o", retired, e.value, retire_value_o);
        assert (retire_tag_o == 4'(retired))
          else report_mismatch("retire_tag_o", retired, 4'(retired), retire_tag_o);
        retired++;
        occupancy--;
      end
      drive_results();
      if (instr_ready_o && next_row < rows.size()) begin
        instr_i    = rows[next_row].instr;
        pc_i       = rows[next_row].pc;
        seen[tail] = 1'b0;   // tag gets reused
        if (rows[next_row].disp) disp_q.push_back(next_row);
        tail++;
        next_row++;
        occupancy++;
      end else begin
        instr_i = '0;
      end
    end

    assert (saw_stall) else report_error("instr_ready_o never dropped at the stall level");
    assert (disp_q.size() == 0) else report_error("dispatched rows left without a packet");
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+logic
+incdir+verif
logic/rob_pkg.sv
logic/rob_store.sv
logic/reg_rename.sv
logic/rs_dispatch.sv
logic/rob_top.sv
verif/rob_tb.sv

//--- Bender.yml
package:
  name: rob

sources:
  - include_dirs:
      - logic
    files:
      - logic/rob_pkg.sv
      - logic/rob_store.sv
      - logic/reg_rename.sv
      - logic/rs_dispatch.sv
      - logic/rob_top.sv
  - target: test
    include_dirs:
      - logic
      - verif
    files:
      - verif/rob_tb.sv
